// ==== run_sim.sh ====
#!/bin/sh
# build and run the plate locator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_plate_locate -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_plate_locate > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/cb_threshold.sv ====
`timescale 1ns/1ps

module cb_threshold (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        vsync,
	input  logic                        href,
	input  logic                        clken,
	input  logic [plate_pkg::pix_w-1:0] red,
	input  logic [plate_pkg::pix_w-1:0] green,
	input  logic [plate_pkg::pix_w-1:0] blue,
	output logic                        bin_vsync,
	output logic                        bin_href,
	output logic                        bin_clken,
	output logic                        bin_bit
);

	// stage one weighted products
	logic [plate_pkg::prod_w-1:0] r_prod;
	logic [plate_pkg::prod_w-1:0] g_prod;
	logic [plate_pkg::prod_w-1:0] b_prod;
	// stage two sum and cb byte
	logic [plate_pkg::prod_w-1:0] cb_sum;
	logic [plate_pkg::pix_w-1:0]  cb_val;
	// sync pipes, bit 1 is the output end
	logic [1:0]                   vsync_sr;
	logic [1:0]                   href_sr;
	logic [1:0]                   clken_sr;

	// ------------------------------------------------------------
	// stage one
	// ------------------------------------------------------------

	// products taken every clock, strobe travels beside them
	always_ff @(posedge clk) begin
		r_prod <= red * plate_pkg::cb_r_coef;
		g_prod <= green * plate_pkg::cb_g_coef;
		b_prod <= blue * plate_pkg::cb_b_coef;
	end

	// ------------------------------------------------------------
	// stage two
	// ------------------------------------------------------------

	// offset first so the sum never goes below zero
	assign cb_sum = plate_pkg::cb_offset + b_prod - r_prod - g_prod;
	// upper byte is cb in 0..255
	assign cb_val = cb_sum[plate_pkg::prod_w-1:plate_pkg::pix_w];

	always_ff @(posedge clk) begin
		bin_bit <= (cb_val > plate_pkg::cb_threshold);
	end

	// sync levels delayed to line up with bin_bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vsync_sr <= '0;
			href_sr  <= '0;
			clken_sr <= '0;
		end else begin
			vsync_sr <= {vsync_sr[0], vsync};
			href_sr  <= {href_sr[0], href};
			clken_sr <= {clken_sr[0], clken};
		end
	end

	assign bin_vsync = vsync_sr[1];
	assign bin_href  = href_sr[1];
	assign bin_clken = clken_sr[1];

endmodule

// ==== source/mask_erode.sv ====
`timescale 1ns/1ps

module mask_erode (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      bin_vsync,
	input  logic                      bin_href,
	input  logic                      bin_clken,
	input  logic                      bin_bit,
	output logic                      ero_vsync,
	output logic                      ero_strobe,
	output logic                      ero_bit,
	output logic [plate_pkg::x_w-1:0] ero_x,
	output logic [plate_pkg::y_w-1:0] ero_y
);

	// pixel taken this clock
	logic                          pix_stb;
	// href one clock back, for the end of a run
	logic                          href_d;
	// position of the incoming mask pixel
	logic [plate_pkg::x_w-1:0]     x_cnt;
	logic [plate_pkg::y_w-1:0]     y_cnt;
	// line_a holds row y-1, line_b holds row y-2
	logic [plate_pkg::img_w-1:0]   line_a;
	logic [plate_pkg::img_w-1:0]   line_b;
	// window columns, {top, mid, bottom}
	logic [2:0]                    col_l;
	logic [2:0]                    col_m;
	logic [2:0]                    col_r;
	// window covers a full 3x3 inside the frame
	logic                          win_full;
	// and of all nine bits
	logic                          win_and;

	assign pix_stb = bin_href & bin_clken;

	// ------------------------------------------------------------
	// raster position
	// ------------------------------------------------------------

	// x restarts whenever href drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_cnt <= '0;
		end else if (!bin_href) begin
			x_cnt <= '0;
		end else if (pix_stb) begin
			x_cnt <= x_cnt + 1'b1;
		end
	end

	// y steps at each href fall, cleared while vsync is low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			href_d <= 1'b0;
			y_cnt  <= '0;
		end else begin
			href_d <= bin_href;
			if (!bin_vsync) begin
				y_cnt <= '0;
			end else if (href_d && !bin_href) begin
				y_cnt <= y_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// line buffers and window
	// ------------------------------------------------------------

	// newest column straight from the buffers and the input
	assign col_r = {line_b[x_cnt], line_a[x_cnt], bin_bit};

	// x >= 2 and y >= 2
	assign win_full = (x_cnt[plate_pkg::x_w-1:1] != '0) && (y_cnt[plate_pkg::y_w-1:1] != '0);
	assign win_and  = &{col_l, col_m, col_r};

	// rows 0 and 1 of a frame overwrite stale buffer data before any use
	always_ff @(posedge clk) begin
		if (pix_stb) begin
			line_b[x_cnt] <= line_a[x_cnt];
			line_a[x_cnt] <= bin_bit;
			col_l         <= col_m;
			col_m         <= col_r;
		end
	end

	// ------------------------------------------------------------
	// result, centre is one up and one left of the input pixel
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ero_vsync  <= 1'b0;
			ero_strobe <= 1'b0;
		end else begin
			ero_vsync  <= bin_vsync;
			ero_strobe <= pix_stb & win_full;
		end
	end

	// border centres are never emitted
	always_ff @(posedge clk) begin
		if (pix_stb) begin
			ero_bit <= win_and;
			ero_x   <= x_cnt - 1'b1;
			ero_y   <= y_cnt - 1'b1;
		end
	end

endmodule

// ==== source/plate_locate_top.sv ====
`timescale 1ns/1ps

module plate_locate_top (
	input  logic                        clk,
	input  logic                        rst_n,
	// camera stream
	input  logic                        vsync,
	input  logic                        href,
	input  logic                        clken,
	input  logic [plate_pkg::pix_w-1:0] red,
	input  logic [plate_pkg::pix_w-1:0] green,
	input  logic [plate_pkg::pix_w-1:0] blue,
	// frame-end plate box
	output logic                        bounds_valid,
	output logic                        plate_found,
	output logic [plate_pkg::y_w-1:0]   plate_up,
	output logic [plate_pkg::y_w-1:0]   plate_down,
	output logic [plate_pkg::x_w-1:0]   plate_left,
	output logic [plate_pkg::x_w-1:0]   plate_right
);

	// ------------------------------------------------------------
	// stage links
	// ------------------------------------------------------------

	// blue mask stream, input timing plus 2 clocks
	logic                      bin_vsync;
	logic                      bin_href;
	logic                      bin_clken;
	logic                      bin_bit;
	// eroded mask with centre coordinates
	logic                      ero_vsync;
	logic                      ero_strobe;
	logic                      ero_bit;
	logic [plate_pkg::x_w-1:0] ero_x;
	logic [plate_pkg::y_w-1:0] ero_y;

	// cb and threshold
	cb_threshold cb_threshold_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.vsync     (vsync),
		.href      (href),
		.clken     (clken),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.bin_vsync (bin_vsync),
		.bin_href  (bin_href),
		.bin_clken (bin_clken),
		.bin_bit   (bin_bit)
	);

	// 3x3 erosion
	mask_erode mask_erode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.bin_vsync  (bin_vsync),
		.bin_href   (bin_href),
		.bin_clken  (bin_clken),
		.bin_bit    (bin_bit),
		.ero_vsync  (ero_vsync),
		.ero_strobe (ero_strobe),
		.ero_bit    (ero_bit),
		.ero_x      (ero_x),
		.ero_y      (ero_y)
	);

	// row / column projection and box report
	plate_projection plate_projection_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.ero_vsync    (ero_vsync),
		.ero_strobe   (ero_strobe),
		.ero_bit      (ero_bit),
		.ero_x        (ero_x),
		.ero_y        (ero_y),
		.bounds_valid (bounds_valid),
		.plate_found  (plate_found),
		.plate_up     (plate_up),
		.plate_down   (plate_down),
		.plate_left   (plate_left),
		.plate_right  (plate_right)
	);

endmodule

// ==== source/plate_pkg.sv ====
package plate_pkg;

	// ------------------------------------------------------------
	// frame geometry
	// ------------------------------------------------------------

	// active pixels per href run
	localparam int img_w = 32;
	// href runs per frame
	localparam int img_h = 24;

	// coordinate widths
	localparam int x_w = 5;
	localparam int y_w = 5;

	// last valid column and row index
	localparam logic [x_w-1:0] x_last = x_w'(img_w - 1);
	localparam logic [y_w-1:0] y_last = y_w'(img_h - 1);

	// ------------------------------------------------------------
	// colour path
	// ------------------------------------------------------------

	// one colour channel
	localparam int pix_w = 8;
	// weighted product and sum width
	localparam int prod_w = 2 * pix_w;

	// cb weights, red and green get subtracted
	localparam logic [pix_w-1:0] cb_r_coef = 8'd43;
	localparam logic [pix_w-1:0] cb_g_coef = 8'd85;
	localparam logic [pix_w-1:0] cb_b_coef = 8'd128;
	// bias before the >>8, keeps the sum in 0..65535
	localparam logic [prod_w-1:0] cb_offset = 16'd32768;

	// mask is 1 for cb strictly above this
	localparam logic [pix_w-1:0] cb_threshold = 8'd150;

	// ------------------------------------------------------------
	// projection
	// ------------------------------------------------------------

	// per-row and per-column hit counters, up to img_w
	localparam int cnt_w = 6;
	// minimum eroded pixels for a row to be part of the plate
	localparam logic [cnt_w-1:0] row_min = 6'd4;
	// same for a column
	localparam logic [cnt_w-1:0] col_min = 6'd3;

endpackage

// ==== source/plate_projection.sv ====
`timescale 1ns/1ps

module plate_projection (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ero_vsync,
	input  logic                      ero_strobe,
	input  logic                      ero_bit,
	input  logic [plate_pkg::x_w-1:0] ero_x,
	input  logic [plate_pkg::y_w-1:0] ero_y,
	output logic                      bounds_valid,
	output logic                      plate_found,
	output logic [plate_pkg::y_w-1:0] plate_up,
	output logic [plate_pkg::y_w-1:0] plate_down,
	output logic [plate_pkg::x_w-1:0] plate_left,
	output logic [plate_pkg::x_w-1:0] plate_right
);

	// hits per row (horizontal projection) and per column (vertical)
	logic [plate_pkg::cnt_w-1:0] row_cnt [plate_pkg::img_h];
	logic [plate_pkg::cnt_w-1:0] col_cnt [plate_pkg::img_w];
	// end of frame detect
	logic                        vsync_d;
	logic                        frame_end;
	// scan state
	logic                        scan_busy;
	logic                        scan_done;
	logic [plate_pkg::x_w-1:0]   scan_idx;
	// qualifying row / column at the scan index
	logic                        row_ok;
	logic                        col_ok;
	// first and last qualifying index so far
	logic                        row_hit;
	logic                        col_hit;
	logic [plate_pkg::y_w-1:0]   row_first;
	logic [plate_pkg::y_w-1:0]   row_last;
	logic [plate_pkg::x_w-1:0]   col_first;
	logic [plate_pkg::x_w-1:0]   col_last;
	logic                        box_ok;

	// falling edge of the delayed vsync
	assign frame_end = vsync_d & ~ero_vsync;

	// ------------------------------------------------------------
	// projection counters
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < plate_pkg::img_h; i++) begin
				row_cnt[i] <= '0;
			end
			for (int j = 0; j < plate_pkg::img_w; j++) begin
				col_cnt[j] <= '0;
			end
		end else if (scan_done) begin
			// ready for the next frame
			for (int i = 0; i < plate_pkg::img_h; i++) begin
				row_cnt[i] <= '0;
			end
			for (int j = 0; j < plate_pkg::img_w; j++) begin
				col_cnt[j] <= '0;
			end
		end else if (ero_strobe && ero_bit) begin
			row_cnt[ero_y] <= row_cnt[ero_y] + 1'b1;
			col_cnt[ero_x] <= col_cnt[ero_x] + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// frame-end scan, one index per clock over img_w columns
	// ------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vsync_d   <= 1'b0;
			scan_busy <= 1'b0;
			scan_done <= 1'b0;
			scan_idx  <= '0;
		end else begin
			vsync_d   <= ero_vsync;
			scan_done <= 1'b0;
			if (frame_end) begin
				scan_busy <= 1'b1;
				scan_idx  <= '0;
			end else if (scan_busy) begin
				scan_idx <= scan_idx + 1'b1;
				if (scan_idx == plate_pkg::x_last) begin
					scan_busy <= 1'b0;
					scan_done <= 1'b1;
				end
			end
		end
	end

	// rows only exist below img_h
	assign col_ok = scan_busy && (col_cnt[scan_idx] >= plate_pkg::col_min);
	assign row_ok = scan_busy && (scan_idx[plate_pkg::y_w-1:0] <= plate_pkg::y_last) &&
		(row_cnt[scan_idx[plate_pkg::y_w-1:0]] >= plate_pkg::row_min);

	// first hit sets the low edge, every hit moves the high edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_hit   <= 1'b0;
			col_hit   <= 1'b0;
			row_first <= '0;
			row_last  <= '0;
			col_first <= '0;
			col_last  <= '0;
		end else if (frame_end) begin
			row_hit <= 1'b0;
			col_hit <= 1'b0;
		end else begin
			if (row_ok) begin
				if (!row_hit) begin
					row_first <= scan_idx[plate_pkg::y_w-1:0];
				end
				row_last <= scan_idx[plate_pkg::y_w-1:0];
				row_hit  <= 1'b1;
			end
			if (col_ok) begin
				if (!col_hit) begin
					col_first <= scan_idx;
				end
				col_last <= scan_idx;
				col_hit  <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// report, held until the next frame end
	// ------------------------------------------------------------

	// need both a row and a column for a box
	assign box_ok = row_hit & col_hit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bounds_valid <= 1'b0;
			plate_found  <= 1'b0;
			plate_up     <= '0;
			plate_down   <= '0;
			plate_left   <= '0;
			plate_right  <= '0;
		end else begin
			bounds_valid <= scan_done;
			if (scan_done) begin
				plate_found <= box_ok;
				plate_up    <= box_ok ? row_first : '0;
				plate_down  <= box_ok ? row_last : '0;
				plate_left  <= box_ok ? col_first : '0;
				plate_right <= box_ok ? col_last : '0;
			end
		end
	end

endmodule

// ==== sources.f ====
+incdir+testbench
source/plate_pkg.sv
source/cb_threshold.sv
source/mask_erode.sv
source/plate_projection.sv
source/plate_locate_top.sv
testbench/plate_locate_asserts.sv
testbench/tb_plate_locate.sv

// ==== testbench/plate_locate_asserts.sv ====
`timescale 1ns/1ps

module plate_locate_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      bounds_valid,
	input logic                      plate_found,
	input logic                      ero_strobe,
	input logic                      scan_busy,
	input logic [plate_pkg::y_w-1:0] plate_up,
	input logic [plate_pkg::y_w-1:0] plate_down,
	input logic [plate_pkg::x_w-1:0] plate_left,
	input logic [plate_pkg::x_w-1:0] plate_right
);

	// report strobe is a single clock
	valid_one_clock: assert property (@(posedge clk) disable iff (!rst_n)
		bounds_valid |=> !bounds_valid)
		else $error("bounds_valid held for more than one clock");

	// a found box is never inverted
	box_ordered: assert property (@(posedge clk) disable iff (!rst_n)
		plate_found |-> (plate_up <= plate_down) && (plate_left <= plate_right))
		else $error("plate box has up > down or left > right");

	// next frame must not reach the counters while they are scanned
	quiet_scan: assert property (@(posedge clk) disable iff (!rst_n)
		scan_busy |-> !ero_strobe)
		else $error("ero_strobe arrived during the frame-end scan");

endmodule

bind plate_projection plate_locate_asserts plate_locate_asserts_i (.*);

// ==== testbench/tb_frame_tasks.svh ====
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// ------------------------------------------------------------
// camera timing
// ------------------------------------------------------------

// idle clocks, href low
task automatic blank_clocks(input int n, input logic vs);
	repeat (n) begin
		@(negedge clk);
		vsync = vs;
		href  = 1'b0;
		clken = 1'b0;
	end
endtask

// one frame in raster order, ends with the vsync-low line
task automatic drive_frame(input bit gated);
	int x;
	reports_before = reports;
	blank_clocks(3, 1'b1);
	for (int y = 0; y < plate_pkg::img_h; y++) begin
		x = 0;
		while (x < plate_pkg::img_w) begin
			@(negedge clk);
			href  = 1'b1;
			// gaps inside the run when gated
			clken = gated ? take_bit() : 1'b1;
			red   = img_r[y][x];
			green = img_g[y][x];
			blue  = img_b[y][x];
			if (clken) begin
				x++;
			end
		end
		blank_clocks(3, 1'b1);
	end
	// two blank lines then vsync low
	blank_clocks(2 * line_clks, 1'b1);
	@(negedge clk);
	vsync = 1'b0;
	href  = 1'b0;
	clken = 1'b0;
	fall_cycle = cycles;
	blank_clocks(line_clks - 1, 1'b0);
endtask

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------

// box from cb threshold, border-zero erosion, row and column minimums
task automatic expect_box();
	int cb;
	bit hit;
	bit row_seen;
	bit col_seen;
	bit mask [plate_pkg::img_h][plate_pkg::img_w];
	int row_hits [plate_pkg::img_h];
	int col_hits [plate_pkg::img_w];
	row_hits = '{default: 0};
	col_hits = '{default: 0};
	for (int y = 0; y < plate_pkg::img_h; y++) begin
		for (int x = 0; x < plate_pkg::img_w; x++) begin
			cb = int'(plate_pkg::cb_offset) + int'(plate_pkg::cb_b_coef) * int'(img_b[y][x])
				- int'(plate_pkg::cb_r_coef) * int'(img_r[y][x])
				- int'(plate_pkg::cb_g_coef) * int'(img_g[y][x]);
			mask[y][x] = ((cb / 256) > int'(plate_pkg::cb_threshold));
		end
	end
	// inner centres only, all nine must be set
	for (int y = 1; y < plate_pkg::img_h - 1; y++) begin
		for (int x = 1; x < plate_pkg::img_w - 1; x++) begin
			hit = 1'b1;
			for (int dy = -1; dy <= 1; dy++) begin
				for (int dx = -1; dx <= 1; dx++) begin
					hit = hit & mask[y + dy][x + dx];
				end
			end
			row_hits[y] += int'(hit);
			col_hits[x] += int'(hit);
		end
	end
	row_seen = 1'b0;
	col_seen = 1'b0;
	for (int y = 0; y < plate_pkg::img_h; y++) begin
		if (row_hits[y] >= int'(plate_pkg::row_min)) begin
			if (!row_seen) begin
				exp_up = y;
			end
			exp_down = y;
			row_seen = 1'b1;
		end
	end
	for (int x = 0; x < plate_pkg::img_w; x++) begin
		if (col_hits[x] >= int'(plate_pkg::col_min)) begin
			if (!col_seen) begin
				exp_left = x;
			end
			exp_right = x;
			col_seen  = 1'b1;
		end
	end
	exp_found = int'(row_seen && col_seen);
	// no box, all borders zero
	if (exp_found == 0) begin
		exp_up    = 0;
		exp_down  = 0;
		exp_left  = 0;
		exp_right = 0;
	end
endtask

// ------------------------------------------------------------
// checking
// ------------------------------------------------------------

task automatic compare_field(input string label, input string name, input int got,
	input int exp);
	checks++;
	if (got != exp) begin
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h (%s)", name, got, exp, label);
		errors++;
	end
endtask

// wait for the frame-end pulse, then compare the captured box
task automatic wait_report(input string label);
	while (reports == reports_before && cycles - fall_cycle < report_limit) begin
		@(negedge clk);
	end
	if (reports == reports_before) begin
		$display("%s: no bounds_valid pulse within %0d clocks of the vsync fall",
			label, report_limit);
		errors++;
	end else begin
		compare_field(label, "plate_found", cap_found, exp_found);
		compare_field(label, "plate_up", cap_up, exp_up);
		compare_field(label, "plate_down", cap_down, exp_down);
		compare_field(label, "plate_left", cap_left, exp_left);
		compare_field(label, "plate_right", cap_right, exp_right);
	end
endtask

// model, drive, check
task automatic frame_and_check(input string label, input bit gated);
	expect_box();
	drive_frame(gated);
	wait_report(label);
endtask

`endif

// ==== testbench/tb_plate_locate.sv ====
`timescale 1ns/1ps

module tb_plate_locate;

	// ------------------------------------------------------------
	// timing constants
	// ------------------------------------------------------------

	localparam int clk_half     = 20;
	// active pixels plus 3 blanking clocks
	localparam int line_clks    = plate_pkg::img_w + 3;
	// active lines, 2 blank lines, 1 vsync-low line, lead-in
	localparam int frame_clks   = (plate_pkg::img_h + 3) * line_clks + 3;
	localparam int timeout_clks = 12 * frame_clks;
	localparam int report_limit = 60;
	localparam logic [31:0] lfsr_seed = 32'h9cd4c8d4;

	logic                        clk;
	logic                        rst_n;
	logic                        vsync;
	logic                        href;
	logic                        clken;
	logic [plate_pkg::pix_w-1:0] red;
	logic [plate_pkg::pix_w-1:0] green;
	logic [plate_pkg::pix_w-1:0] blue;
	logic                        bounds_valid;
	logic                        plate_found;
	logic [plate_pkg::y_w-1:0]   plate_up;
	logic [plate_pkg::y_w-1:0]   plate_down;
	logic [plate_pkg::x_w-1:0]   plate_left;
	logic [plate_pkg::x_w-1:0]   plate_right;

	// test image with one array per channel
	logic [plate_pkg::pix_w-1:0] img_r [plate_pkg::img_h][plate_pkg::img_w];
	logic [plate_pkg::pix_w-1:0] img_g [plate_pkg::img_h][plate_pkg::img_w];
	logic [plate_pkg::pix_w-1:0] img_b [plate_pkg::img_h][plate_pkg::img_w];
	logic [31:0]                 lfsr_state;
	int cycles = 0;
	int reports = 0;
	int reports_before = 0;
	int fall_cycle = 0;
	int errors = 0;
	int checks = 0;
	// last report and the model's box
	int cap_found;
	int cap_up;
	int cap_down;
	int cap_left;
	int cap_right;
	int exp_found;
	int exp_up;
	int exp_down;
	int exp_left;
	int exp_right;

	plate_locate_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_half) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// box sampled mid-cycle on the pulse
	always @(negedge clk) begin
		if (bounds_valid) begin
			cap_found = plate_found;
			cap_up    = plate_up;
			cap_down  = plate_down;
			cap_left  = plate_left;
			cap_right = plate_right;
			reports   = reports + 1;
		end
	end

	initial begin
		wait (cycles >= timeout_clks);
		$display("timeout after %0d clocks with %0d errors", timeout_clks, errors);
		$display("Testbench failed");
		$finish;
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic take_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(take_bit());
		end
		return v;
	endfunction

	`include "tb_frame_tasks.svh"

	// ------------------------------------------------------------
	// image setup and directed tests
	// ------------------------------------------------------------

	// cb 128 sits well below threshold
	task automatic fill_grey();
		foreach (img_r[y, x]) begin
			img_r[y][x] = 8'd128;
			img_g[y][x] = 8'd128;
			img_b[y][x] = 8'd128;
		end
	endtask

	task automatic paint_blue(input int x0, input int x1, input int y0, input int y1);
		for (int y = y0; y <= y1; y++) begin
			for (int x = x0; x <= x1; x++) begin
				img_r[y][x] = 8'd0;
				img_g[y][x] = 8'd0;
				img_b[y][x] = 8'd255;
			end
		end
	endtask

	task automatic check_reset_state();
		compare_field("after reset", "bounds_valid", bounds_valid, 0);
		compare_field("after reset", "plate_found", plate_found, 0);
		compare_field("after reset", "plate_up", plate_up, 0);
		compare_field("after reset", "plate_down", plate_down, 0);
		compare_field("after reset", "plate_left", plate_left, 0);
		compare_field("after reset", "plate_right", plate_right, 0);
	endtask

	// even grid so no two points touch
	task automatic erode_isolated_pixels();
		int px;
		int py;
		fill_grey();
		repeat (20) begin
			px = 2 * take_bits(4);
			py = 2 * (take_bits(4) % 12);
			paint_blue(px, px, py, py);
		end
		frame_and_check("isolated pixels", 1'b0);
	endtask

	initial begin
		lfsr_state = lfsr_seed;
		rst_n = 1'b0;
		vsync = 1'b1;
		href  = 1'b0;
		clken = 1'b0;
		red   = '0;
		green = '0;
		blue  = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check_reset_state();
		fill_grey();
		frame_and_check("grey frame", 1'b0);
		paint_blue(6, 21, 8, 15);
		frame_and_check("blue rectangle", 1'b0);
		erode_isolated_pixels();
		// back to back frames so the counters must clear in between
		fill_grey();
		paint_blue(15, 28, 12, 20);
		frame_and_check("first of two", 1'b0);
		fill_grey();
		paint_blue(2, 12, 3, 7);
		frame_and_check("second of two", 1'b0);
		fill_grey();
		paint_blue(6, 21, 8, 15);
		frame_and_check("gated clken", 1'b1);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
